// ==== files.f ====
src/rv_isa_pkg.sv
src/core_pkg.sv
src/instr_mem.sv
src/insn_decoder.sv
src/reg_file.sv
src/alu.sv
src/pc_unit.sv
src/rv_core_top.sv
test/clock_gen.sv
test/rv_core_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/10ps

module alu (
  input  core_pkg::ctrl_t   ctrl,
  input  rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::word_t rs1_data,
  input  rv_isa_pkg::word_t rs2_data,
  output rv_isa_pkg::word_t result
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  assign op_a  = rs1_data;
  assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0]; // RV32 shifts use five bits only

  always_comb begin
    case (ctrl.alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = op_a - op_b;
      alu_sll:  result = op_a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:  result = op_a ^ op_b;
      alu_srl:  result = op_a >> shamt;
      alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
      alu_or:   result = op_a | op_b;
      alu_and:  result = op_a & op_b;
      alu_pass_b: begin
        result = op_b;
      end
      alu_pc_plus_b: begin
        result = pc + op_b;
      end
      alu_pc_plus_4: begin
        result = pc + 32'd4; // Return address
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== src/core_pkg.sv ====
package core_pkg;

  // Operations the ALU knows about
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b,    // LUI
    alu_pc_plus_b, // AUIPC
    alu_pc_plus_4  // Link value of JAL and JALR
  } alu_op_e;

  // Decoded control word for one instruction
  typedef struct packed {
    alu_op_e                    alu_op;
    logic                       use_imm;  // Operand b is the immediate
    rv_isa_pkg::word_t          imm;
    logic                       rf_we;
    rv_isa_pkg::reg_addr_t      rd;
    logic                       is_branch;
    rv_isa_pkg::funct3_branch_e branch_cond;
    logic                       is_jal;
    logic                       is_jalr;
    logic                       is_halt;  // ECALL
  } ctrl_t;

  // One retired instruction as seen from outside
  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::word_t     pc;
    rv_isa_pkg::word_t     insn;
    logic                  rf_we;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     wdata;
    rv_isa_pkg::word_t     next_pc;
  } retire_t;

endpackage

// ==== src/insn_decoder.sv ====
`timescale 1ns/10ps

module insn_decoder (
  input  rv_isa_pkg::word_t     insn,
  output rv_isa_pkg::reg_addr_t rs1,
  output rv_isa_pkg::reg_addr_t rs2,
  output core_pkg::ctrl_t       ctrl
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  insn_fields_t fields;
  opcode_e      opcode;
  word_t        imm_i;
  word_t        imm_b;
  word_t        imm_j;
  word_t        imm_u;
  alu_op_e      arith_op;
  logic         is_ecall;

  assign fields = insn;
  assign opcode = opcode_e'(fields.opcode);
  assign rs1    = fields.rs1;
  assign rs2    = fields.rs2;

  // Immediate formats, all sign-extended from bit 31
  assign imm_i = {{(xlen-12){insn[31]}}, insn[31:20]};
  assign imm_b = {{(xlen-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{(xlen-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // Only the all-zero encoding above the opcode is ECALL
  assign is_ecall = (insn[31:7] == '0);

  // funct3 and bit 30 to ALU operation
  always_comb begin
    case (funct3_alu_e'(fields.funct3))
      f3_add: begin
        // Bit 30 means SUB only in the register-register form
        if (opcode == op_reg_reg && fields.funct7[5]) begin
          arith_op = alu_sub;
        end else begin
          arith_op = alu_add;
        end
      end
      f3_sll:  arith_op = alu_sll;
      f3_slt:  arith_op = alu_slt;
      f3_sltu: arith_op = alu_sltu;
      f3_xor:  arith_op = alu_xor;
      f3_srl:  arith_op = fields.funct7[5] ? alu_sra : alu_srl;
      f3_or:   arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    ctrl = '0; // No write, no jump, no halt

    case (opcode)
      op_lui: begin
        ctrl.alu_op  = alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.rf_we   = 1'b1;
        ctrl.rd      = fields.rd;
      end
      op_auipc: begin
        ctrl.alu_op  = alu_pc_plus_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.rf_we   = 1'b1;
        ctrl.rd      = fields.rd;
      end
      op_reg_imm: begin
        ctrl.alu_op  = arith_op;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_i; // Shift amount sits in the low five bits
        ctrl.rf_we   = 1'b1;
        ctrl.rd      = fields.rd;
      end
      op_reg_reg: begin
        ctrl.alu_op = arith_op;
        ctrl.rf_we  = 1'b1;
        ctrl.rd     = fields.rd;
      end
      op_jal: begin
        ctrl.alu_op = alu_pc_plus_4;
        ctrl.imm    = imm_j;
        ctrl.rf_we  = 1'b1;
        ctrl.rd     = fields.rd;
        ctrl.is_jal = 1'b1;
      end
      op_jalr: begin
        ctrl.alu_op  = alu_pc_plus_4;
        ctrl.imm     = imm_i;
        ctrl.rf_we   = 1'b1;
        ctrl.rd      = fields.rd;
        ctrl.is_jalr = 1'b1;
      end
      op_branch: begin
        ctrl.imm         = imm_b;
        ctrl.is_branch   = 1'b1;
        ctrl.branch_cond = funct3_branch_e'(fields.funct3);
      end
      op_system: begin
        ctrl.is_halt = is_ecall;
      end
      default: begin
        // FENCE and anything unknown fall through as a no-op
      end
    endcase
  end

endmodule

// ==== src/instr_mem.sv ====
`timescale 1ns/10ps

module instr_mem #(
  parameter int imem_words = 1024
) (
  input  logic                          clk,
  input  logic                          load_we,
  input  logic [$clog2(imem_words)-1:0] load_addr,
  input  rv_isa_pkg::word_t             load_data,
  input  rv_isa_pkg::word_t             pc,
  output rv_isa_pkg::word_t             insn
);
  import rv_isa_pkg::*;

  localparam int addr_w = $clog2(imem_words);

  word_t mem [imem_words];

  logic [addr_w-1:0] fetch_idx;

  // Byte address to word index, upper bits dropped so the index wraps
  assign fetch_idx = pc[addr_w+1:2];

  // Program load, one word per strobe
  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_data;
    end
  end

  assign insn = mem[fetch_idx]; // Combinational fetch

endmodule

// ==== src/pc_unit.sv ====
`timescale 1ns/10ps

module pc_unit #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,
  input  core_pkg::ctrl_t   ctrl,
  input  rv_isa_pkg::word_t rs1_data,
  input  rv_isa_pkg::word_t rs2_data,
  output rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t next_pc,
  output logic              commit,
  output logic              halt
);
  import rv_isa_pkg::*;

  logic  cond_true;
  logic  taken;
  word_t pc_plus_4;
  word_t rel_target;
  word_t jalr_target;

  // Branch comparison on the raw register values
  always_comb begin
    case (ctrl.branch_cond)
      beq:     cond_true = (rs1_data == rs2_data);
      bne:     cond_true = (rs1_data != rs2_data);
      blt:     cond_true = $signed(rs1_data) < $signed(rs2_data);
      bge:     cond_true = $signed(rs1_data) >= $signed(rs2_data);
      bltu:    cond_true = rs1_data < rs2_data;
      bgeu:    cond_true = rs1_data >= rs2_data;
      default: cond_true = 1'b0; // Reserved funct3 never branches
    endcase
  end

  assign taken       = (ctrl.is_branch && cond_true) || ctrl.is_jal;
  assign pc_plus_4   = pc + 32'd4;
  assign rel_target  = pc + ctrl.imm;
  assign jalr_target = (rs1_data + ctrl.imm) & ~word_t'(1);

  always_comb begin
    if (ctrl.is_jalr) begin
      next_pc = jalr_target;
    end else if (taken) begin
      next_pc = rel_target;
    end else begin
      next_pc = pc_plus_4;
    end
  end

  assign commit = run && !halt;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (commit) begin
      pc <= next_pc;
      if (ctrl.is_halt) begin
        halt <= 1'b1; // Sticky until reset
      end
    end
  end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  rv_isa_pkg::reg_addr_t rd,
  input  rv_isa_pkg::word_t     wdata,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);
  import rv_isa_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/10ps

module rv_core_top #(
  parameter int                imem_words = 1024,
  parameter rv_isa_pkg::word_t reset_pc   = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          run,
  input  logic                          load_we,
  input  logic [$clog2(imem_words)-1:0] load_addr,
  input  rv_isa_pkg::word_t             load_data,
  output logic                          halt,
  output core_pkg::retire_t             retire
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  word_t     pc;
  word_t     next_pc;
  word_t     insn;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     wdata;
  reg_addr_t rs1;
  reg_addr_t rs2;
  ctrl_t     ctrl;
  logic      commit;
  logic      rf_we;

  assign rf_we = ctrl.rf_we && commit; // No writes while stalled or halted

  instr_mem #(
    .imem_words(imem_words)
  ) u_imem (
    .clk      (clk),
    .load_we  (load_we),
    .load_addr(load_addr),
    .load_data(load_data),
    .pc       (pc),
    .insn     (insn)
  );

  insn_decoder u_dec (
    .insn(insn),
    .rs1 (rs1),
    .rs2 (rs2),
    .ctrl(ctrl)
  );

  reg_file u_rf (
    .clk     (clk),
    .rst     (rst),
    .we      (rf_we),
    .rd      (ctrl.rd),
    .wdata   (wdata),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  alu u_alu (
    .ctrl    (ctrl),
    .pc      (pc),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .result  (wdata)
  );

  pc_unit #(
    .reset_pc(reset_pc)
  ) u_pc (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .ctrl    (ctrl),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .pc      (pc),
    .next_pc (next_pc),
    .commit  (commit),
    .halt    (halt)
  );

  // Retire record straight off the datapath wires
  assign retire = '{
    valid:   commit,
    pc:      pc,
    insn:    insn,
    rf_we:   ctrl.rf_we,
    rd:      ctrl.rd,
    wdata:   wdata,
    next_pc: next_pc
  };

endmodule

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // Datapath width
  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    op_lui      = 7'b0110111,
    op_auipc    = 7'b0010111,
    op_jal      = 7'b1101111,
    op_jalr     = 7'b1100111,
    op_branch   = 7'b1100011,
    op_reg_imm  = 7'b0010011,
    op_reg_reg  = 7'b0110011,
    op_misc_mem = 7'b0001111, // FENCE
    op_system   = 7'b1110011  // ECALL and friends
  } opcode_e;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    f3_add  = 3'b000, // Also SUB when bit 30 is set (register form only)
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_srl  = 3'b101, // Also SRA when bit 30 is set
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } funct3_alu_e;

  // funct3 of the conditional branches
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } funct3_branch_e;

  // R-type field layout, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } insn_fields_t;

endpackage

// ==== test/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen #(
  parameter int period       = 100,
  parameter int reset_cycles = 10
) (
  input  logic restart, // One-cycle pulse starts another reset
  output logic clk,
  output logic rst
);

  int unsigned hold_cnt = reset_cycles; // Reset from time zero

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (restart) begin
      hold_cnt <= reset_cycles;
    end else if (hold_cnt != 0) begin
      hold_cnt <= hold_cnt - 1;
    end
  end

  assign rst = (hold_cnt != 0); // Changes only just after a rising edge

endmodule

// ==== test/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb;
  import rv_isa_pkg::*;
  import core_pkg::*;

  localparam int    imem_words = 1024;
  localparam int    addr_w     = $clog2(imem_words);
  localparam word_t reset_pc   = '0;
  localparam int    clk_period = 100;
  localparam int    num_tests  = 10;
  localparam int    min_len    = 12;
  localparam int    max_len    = 48;
  // Cycles per test for reset, load, run and the tail after halt
  localparam int    watchdog_cycles = num_tests * (2 * max_len + 30) + 50;
  localparam word_t ecall_insn = 32'h0000_0073;
  localparam word_t fence_insn = 32'h0ff0_000f;

  logic              clk;
  logic              rst;
  logic              restart;
  logic              run;
  logic              load_we;
  logic [addr_w-1:0] load_addr;
  word_t             load_data;
  logic              halt;
  retire_t           retire;

  // Program image and ISA model state
  word_t prog [max_len];
  int    prog_len;
  word_t model_regs [32];
  word_t model_pc;
  logic  model_halted;
  logic  expect_retire; // Previous cycle retired something other than ECALL
  logic  halt_expected; // ECALL has retired since the last reset
  int    error_count = 0;

  clock_gen #(.period(clk_period), .reset_cycles(10)) u_clk (
    .restart(restart),
    .clk    (clk),
    .rst    (rst)
  );

  rv_core_top #(
    .imem_words(imem_words),
    .reset_pc  (reset_pc)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .load_we  (load_we),
    .load_addr(load_addr),
    .load_data(load_data),
    .halt     (halt),
    .retire   (retire)
  );

  task automatic check_value(input string what, input word_t got, input word_t expected);
    if (got !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg_reg};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd, input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // Mostly x0..x7 so that equal operands and x0 writes come up often
  function automatic reg_addr_t pick_reg();
    if ($urandom_range(0, 3) == 0) begin
      return reg_addr_t'($urandom_range(0, 31));
    end
    return reg_addr_t'($urandom_range(0, 7));
  endfunction

  // Expected value of an OP or OP-IMM instruction
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    word_t r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Executes one instruction on the model and returns its retire record
  function automatic retire_t model_step(input word_t insn);
    retire_t   r;
    reg_addr_t rd;
    word_t     a;
    word_t     b;
    word_t     imm_i;
    word_t     imm_b;
    word_t     imm_j;
    word_t     imm_u;
    logic      taken;
    rd    = insn[11:7];
    a     = model_regs[insn[19:15]];
    b     = model_regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    imm_u = {insn[31:12], 12'h000};
    r         = '0;
    r.valid   = 1'b1;
    r.pc      = model_pc;
    r.insn    = insn;
    r.rd      = rd;
    r.next_pc = model_pc + 32'd4;
    case (insn[6:0])
      op_lui: begin
        r.rf_we = 1'b1;
        r.wdata = imm_u;
      end
      op_auipc: begin
        r.rf_we = 1'b1;
        r.wdata = model_pc + imm_u;
      end
      op_jal: begin
        r.rf_we   = 1'b1;
        r.wdata   = model_pc + 32'd4;
        r.next_pc = model_pc + imm_j;
      end
      op_jalr: begin
        r.rf_we   = 1'b1;
        r.wdata   = model_pc + 32'd4;
        r.next_pc = (a + imm_i) & 32'hffff_fffe; // Target read before rd is written
      end
      op_branch: begin
        case (insn[14:12])
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken) begin
          r.next_pc = model_pc + imm_b;
        end
      end
      op_reg_imm: begin
        r.rf_we = 1'b1;
        r.wdata = alu_ref(insn[14:12], insn[30] && insn[14:12] == 3'b101, a, imm_i);
      end
      op_reg_reg: begin
        r.rf_we = 1'b1;
        r.wdata = alu_ref(insn[14:12], insn[30], a, b);
      end
      default: begin
        model_halted = (insn == ecall_insn); // FENCE only moves pc on
      end
    endcase
    if (r.rf_we && rd != '0) begin
      model_regs[rd] = r.wdata;
    end
    model_pc = r.next_pc;
    return r;
  endfunction

  // Random program with forward jumps only and a closing ECALL
  task automatic build_program();
    int          i;
    int          kind;
    int          target;
    logic [2:0]  f3;
    logic [11:0] imm12;
    reg_addr_t   rx;
    bit          landed [max_len]; // Slot is the target of an earlier jump
    prog_len = $urandom_range(min_len, max_len);
    landed   = '{default: 1'b0};
    i = 0;
    while (i < prog_len - 1) begin
      kind = $urandom_range(0, 9);
      f3   = 3'($urandom_range(0, 7));
      if (kind <= 2) begin
        imm12 = 12'($urandom);
        if (f3 == 3'b001) begin
          imm12 = {7'b0, imm12[4:0]};
        end else if (f3 == 3'b101) begin
          imm12 = {1'b0, imm12[10], 5'b0, imm12[4:0]}; // SRLI or SRAI
        end
        prog[i] = enc_i(imm12, pick_reg(), f3, pick_reg(), op_reg_imm);
      end else if (kind <= 4) begin
        prog[i] = enc_r(((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ?
                        7'h20 : 7'h00, pick_reg(), pick_reg(), f3, pick_reg());
      end else if (kind == 5) begin
        prog[i] = enc_u(20'($urandom), pick_reg(),
                        ($urandom_range(0, 1) == 1) ? op_lui : op_auipc);
      end else if (kind == 6) begin
        f3 = 3'($urandom_range(0, 5));
        if (f3 >= 3'd2) begin
          f3 = f3 + 3'd2; // Skip the two reserved conditions
        end
        target         = $urandom_range(i + 1, prog_len - 1);
        landed[target] = 1'b1;
        prog[i]        = enc_b(13'((target - i) * 4), pick_reg(), pick_reg(), f3);
      end else if (kind == 7) begin
        target         = $urandom_range(i + 1, prog_len - 1);
        landed[target] = 1'b1;
        prog[i]        = enc_j(21'((target - i) * 4), pick_reg());
      end else if (kind == 8 && i + 2 < prog_len && !landed[i + 1]) begin
        // AUIPC gives JALR a base of its own pc. Odd offsets test bit 0 clearing
        // A jump that landed on the JALR would skip the AUIPC
        rx             = reg_addr_t'($urandom_range(1, 31));
        target         = $urandom_range(i + 2, prog_len - 1);
        landed[target] = 1'b1;
        prog[i]        = enc_u(20'h0, rx, op_auipc);
        prog[i + 1]    = enc_i(12'((target - i) * 4 + $urandom_range(0, 1)), rx, 3'b000,
                               pick_reg(), op_jalr);
        i++;
      end else begin
        prog[i] = fence_insn;
      end
      i++;
    end
    prog[prog_len - 1] = ecall_insn;
  endtask

  task automatic reset_core();
    @(posedge clk);
    restart <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end
    check_value("halt after reset", halt, 1'b0);
    check_value("retire.valid after reset", retire.valid, 1'b0);
    model_pc     = reset_pc;
    model_halted = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      load_we   <= 1'b1;
      load_addr <= addr_w'(i);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_we <= 1'b0;
  endtask

  // Retire record is stable around the falling edge
  always @(negedge clk) begin
    retire_t expected;
    if (rst) begin
      expect_retire = 1'b0;
      halt_expected = 1'b0;
    end else begin
      if (halt_expected) begin
        check_value("halt after ECALL", halt, 1'b1);
        check_value("retire.valid while halted", retire.valid, 1'b0);
      end else if (expect_retire) begin
        check_value("retire.valid in next cycle", retire.valid, 1'b1);
      end
      if (retire.valid) begin
        expected = model_step(prog[model_pc[31:2]]);
        check_value("pc", retire.pc, expected.pc);
        check_value("insn", retire.insn, expected.insn);
        check_value("rf_we", retire.rf_we, expected.rf_we);
        if (expected.rf_we) begin
          check_value("rd", retire.rd, expected.rd);
          check_value("wdata", retire.wdata, expected.wdata);
        end
        check_value("next_pc", retire.next_pc, expected.next_pc);
        expect_retire = !model_halted;
        halt_expected = model_halted;
      end
    end
  end

  initial begin : stimulus
    restart   = 1'b0;
    run       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(96288));
    for (int t = 0; t < num_tests; t++) begin
      build_program();
      reset_core();
      load_program();
      @(posedge clk);
      run <= 1'b1;
      @(negedge clk);
      while (!halt) begin
        @(negedge clk);
      end
      repeat (3) @(posedge clk); // Core must stay quiet while run is still high
      run <= 1'b0;
      check_value("ECALL reached by model", model_halted, 1'b1);
    end
    @(posedge clk);
    if (error_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("=== FAIL ===");
      $fatal(1, "Errors were found");
    end
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("Timeout: halt never arrived within %0d cycles", watchdog_cycles);
    $display("=== FAIL ===");
    $fatal(1, "Watchdog expired");
  end

endmodule
